// File: rv_isa_pkg.sv
// RV32I encodings for the OP and OP-IMM groups only; other major opcodes have no named value
package rv_isa_pkg;

    // Register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // ----------------------------------------
    // Major opcodes
    // ----------------------------------------
    typedef enum logic [6:0] {
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    // funct3 values shared by the register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ----------------------------------------
    // Instruction word layouts
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } rv_r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } rv_i_type_t;

    // Same word seen as R-type or I-type; rd, rs1 and funct3 overlap
    typedef union packed {
        rv_r_type_t r;
        rv_i_type_t i;
    } rv_instr_u;

endpackage

// File: core_pkg.sv
// Core-wide widths and the operation code issued to execute; only the ten ALU functions exist
package core_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int xlen    = 32;
    localparam int shamt_w = $clog2(xlen);

    // ----------------------------------------
    // Execution unit classes
    // ----------------------------------------
    // Code 2'b00 is left for the NOP, which uses no unit
    typedef enum logic [1:0] {
        ADDER_UNIT   = 2'b01,
        LOGICAL_UNIT = 2'b10,
        SHIFTER_UNIT = 2'b11
    } exec_unit_e;

    // ----------------------------------------
    // Issued operation
    // ----------------------------------------
    // Upper two bits name the unit, lower two pick the function inside it
    typedef enum logic [3:0] {
        OP_NOP  = 4'b0000,

        // Adder unit, compares come from the subtraction
        OP_ADD  = {ADDER_UNIT, 2'b00},
        OP_SUB  = {ADDER_UNIT, 2'b01},
        OP_SLT  = {ADDER_UNIT, 2'b10},
        OP_SLTU = {ADDER_UNIT, 2'b11},

        // Logical unit
        OP_XOR  = {LOGICAL_UNIT, 2'b00},
        OP_OR   = {LOGICAL_UNIT, 2'b01},
        OP_AND  = {LOGICAL_UNIT, 2'b10},

        // Shifter unit
        OP_SLL  = {SHIFTER_UNIT, 2'b00},
        OP_SRL  = {SHIFTER_UNIT, 2'b01},
        OP_SRA  = {SHIFTER_UNIT, 2'b10}
    } alu_op_e;

endpackage

// File: pipeline_if.sv
// Decode-to-execute issue bus and combinational register read bus; no clocking inside
`timescale 1ns/1ns

// ----------------------------------------
// Issue bus, driven by the decode stage register
// ----------------------------------------
interface issue_if;
    import core_pkg::*;
    import rv_isa_pkg::*;

    logic            valid;
    alu_op_e         op;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    reg_addr_t       rd;

    modport issue_src (output valid, output op, output operand_a, output operand_b, output rd);
    modport issue_dst (input valid, input op, input operand_a, input operand_b, input rd);
endinterface

// ----------------------------------------
// Register read bus, answered in the same cycle
// ----------------------------------------
interface reg_read_if;
    import core_pkg::*;
    import rv_isa_pkg::*;

    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    modport reader (output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);
    modport bank (input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);
endinterface

// File: fetch_decode.sv
// PC steps by four with no branches; unknown opcodes issue as NOP; instruction arrives same cycle
`timescale 1ns/1ns

module fetch_decode #(
    parameter logic [31:0] reset_address = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  rv_isa_pkg::rv_instr_u instruction_i,
    output logic [31:0]           instruction_address_o,
    reg_read_if.reader            rf,
    issue_if.issue_src            issue
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [31:0]     pc_q;
    alu_op_e         decoded_op;
    logic [xlen-1:0] decoded_b;
    reg_addr_t       decoded_rd;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            alt_bit;
    logic            hazard;

    // Function select from funct3; alt is instruction bit 30
    function automatic alu_op_e map_funct3(input logic [2:0] funct3, input logic alt,
                                           input logic is_reg);
        alu_op_e op;
        case (funct3)
            F3_ADD_SUB: op = (alt && is_reg) ? OP_SUB : OP_ADD;
            F3_SLL:     op = OP_SLL;
            F3_SLT:     op = OP_SLT;
            F3_SLTU:    op = OP_SLTU;
            F3_XOR:     op = OP_XOR;
            F3_SRL_SRA: op = alt ? OP_SRA : OP_SRL;
            F3_OR:      op = OP_OR;
            default:    op = OP_AND;
        endcase
        return op;
    endfunction

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    assign instruction_address_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= reset_address;
        end else if (!stall_i && !hazard) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    assign rf.rs1_addr = instruction_i.r.rs1;
    assign rf.rs2_addr = instruction_i.r.rs2;

    always_comb begin
        decoded_op = OP_NOP;
        decoded_b  = '0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        alt_bit    = 1'b0;
        case (instruction_i.r.opcode)
            OPCODE_OP: begin
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                alt_bit    = instruction_i.r.funct7[5];
                decoded_op = map_funct3(instruction_i.r.funct3, alt_bit, 1'b1);
                decoded_b  = rf.rs2_data;
            end
            OPCODE_OP_IMM: begin
                uses_rs1   = 1'b1;
                alt_bit    = instruction_i.i.imm[10];
                decoded_op = map_funct3(instruction_i.i.funct3, alt_bit, 1'b0);
                if (instruction_i.i.funct3 == F3_SLL || instruction_i.i.funct3 == F3_SRL_SRA) begin
                    // Only the shift amount, as the upper immediate bits carry the SRAI flag
                    decoded_b = {{(xlen-shamt_w){1'b0}}, instruction_i.i.imm[shamt_w-1:0]};
                end else begin
                    decoded_b = {{(xlen-12){instruction_i.i.imm[11]}}, instruction_i.i.imm};
                end
            end
            default: begin
                decoded_op = OP_NOP;
            end
        endcase
    end

    // A NOP never names a destination, so it can not cause a hazard later
    assign decoded_rd = (decoded_op == OP_NOP) ? '0 : instruction_i.r.rd;

    // ----------------------------------------
    // Hazard against the operation now in execute
    // ----------------------------------------
    assign hazard = issue.valid && (issue.rd != '0) &&
                    ((uses_rs1 && (instruction_i.r.rs1 == issue.rd)) ||
                     (uses_rs2 && (instruction_i.r.rs2 == issue.rd)));

    // ----------------------------------------
    // Decode stage register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (!stall_i) begin
            issue.valid <= !hazard;  // bubble on hazard
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            issue.op        <= decoded_op;
            issue.operand_a <= rf.rs1_data;
            issue.operand_b <= decoded_b;
            issue.rd        <= decoded_rd;
        end
    end

    // The same word is decoded again and finds its producer in write-back
    assert property (@(posedge clk) disable iff (reset)
        hazard && !stall_i |=> $stable(instruction_i) && !hazard);

endmodule

// File: register_bank.sv
// Registers x1 to x31 with no reset; x0 reads zero; write-back data bypasses both read ports
`timescale 1ns/1ns

module register_bank (
    input  logic                     clk,
    input  logic                     reset,
    reg_read_if.bank                 rf,
    input  logic                     wb_enable_i,
    input  rv_isa_pkg::reg_addr_t    wb_addr_i,
    input  logic [core_pkg::xlen-1:0] wb_data_i
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [xlen-1:0] regs [1:31];

    // Read with x0 tied low and the write in flight taking priority
    function automatic logic [xlen-1:0] bypassed_read(input reg_addr_t addr);
        logic [xlen-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wb_enable_i && (wb_addr_i == addr)) begin
            data = wb_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wb_enable_i && (wb_addr_i != '0)) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------
    always_comb begin
        rf.rs1_data = bypassed_read(rf.rs1_addr);
        rf.rs2_data = bypassed_read(rf.rs2_addr);
    end

    // Execute must never retire a write to x0
    assert property (@(posedge clk) disable iff (reset)
        !(wb_enable_i && (wb_addr_i == '0)));

endmodule

// File: execute_unit.sv
// Single-cycle ALU with one write-back register; the enable output drops in any stalled cycle
`timescale 1ns/1ns

module execute_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    issue_if.issue_dst                issue,
    output logic                      wb_enable_o,
    output rv_isa_pkg::reg_addr_t     wb_addr_o,
    output logic [core_pkg::xlen-1:0] wb_data_o
);
    import core_pkg::*;

    logic [3:0]         op_bits;
    exec_unit_e         unit;
    logic [shamt_w-1:0] shamt;
    logic [xlen:0]      diff_wide;
    logic [xlen-1:0]    sum;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [xlen-1:0]    adder_result;
    logic [xlen-1:0]    logic_result;
    logic [xlen-1:0]    shift_result;
    logic [xlen-1:0]    result;
    logic               writes_rd;
    logic               enable_q;

    assign op_bits = issue.op;
    assign unit    = exec_unit_e'(op_bits[3:2]);
    assign shamt   = issue.operand_b[shamt_w-1:0];

    // ----------------------------------------
    // Adder unit
    // ----------------------------------------
    assign sum         = issue.operand_a + issue.operand_b;
    assign diff_wide   = {1'b0, issue.operand_a} - {1'b0, issue.operand_b};
    assign lt_unsigned = diff_wide[xlen];
    // Signs differ: the negative one is smaller
    assign lt_signed   = (issue.operand_a[xlen-1] != issue.operand_b[xlen-1]) ?
                         issue.operand_a[xlen-1] : diff_wide[xlen-1];

    always_comb begin
        case (issue.op)
            OP_SUB:  adder_result = diff_wide[xlen-1:0];
            OP_SLT:  adder_result = {{(xlen-1){1'b0}}, lt_signed};
            OP_SLTU: adder_result = {{(xlen-1){1'b0}}, lt_unsigned};
            default: adder_result = sum;
        endcase
    end

    // ----------------------------------------
    // Logical and shifter units
    // ----------------------------------------
    always_comb begin
        case (issue.op)
            OP_XOR:  logic_result = issue.operand_a ^ issue.operand_b;
            OP_OR:   logic_result = issue.operand_a | issue.operand_b;
            default: logic_result = issue.operand_a & issue.operand_b;
        endcase
    end

    always_comb begin
        case (issue.op)
            OP_SLL:  shift_result = issue.operand_a << shamt;
            OP_SRA:  shift_result = $signed(issue.operand_a) >>> shamt;
            default: shift_result = issue.operand_a >> shamt;
        endcase
    end

    always_comb begin
        case (unit)
            ADDER_UNIT:   result = adder_result;
            LOGICAL_UNIT: result = logic_result;
            SHIFTER_UNIT: result = shift_result;
            default:      result = '0;
        endcase
    end

    // ----------------------------------------
    // Write-back register
    // ----------------------------------------
    assign writes_rd = issue.valid && (issue.op != OP_NOP) && (issue.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q <= 1'b0;
        end else if (!stall_i) begin
            enable_q <= writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_addr_o <= issue.rd;
            wb_data_o <= result;
        end
    end

    // Held entry retires once, in the first cycle after the stall
    assign wb_enable_o = enable_q && !stall_i;

    assert property (@(posedge clk) disable iff (reset) wb_enable_o |-> (wb_addr_o != '0));

endmodule

// File: rv_core_top.sv
// Three-stage RV32I ALU core; instruction memory must answer in the cycle the address is shown
`timescale 1ns/1ns

module rv_core_top #(
    parameter logic [31:0] reset_address = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  logic [31:0] instruction_i,
    output logic [31:0] instruction_address_o,
    output logic        rf_write_enable_o,
    output logic [4:0]  rf_write_addr_o,
    output logic [31:0] rf_write_data_o
);

    // ----------------------------------------
    // Internal buses
    // ----------------------------------------
    issue_if    issue_bus ();
    reg_read_if read_bus ();

    logic        wb_enable;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // Fetch, decode and the decode stage register
    fetch_decode #(
        .reset_address(reset_address)
    ) u_fetch_decode (
        .clk                  (clk),
        .reset                (reset),
        .stall_i              (stall_i),
        .instruction_i        (instruction_i),
        .instruction_address_o(instruction_address_o),
        .rf                   (read_bus.reader),
        .issue                (issue_bus.issue_src)
    );

    register_bank u_register_bank (
        .clk        (clk),
        .reset      (reset),
        .rf         (read_bus.bank),
        .wb_enable_i(wb_enable),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_data)
    );

    execute_unit u_execute_unit (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .issue      (issue_bus.issue_dst),
        .wb_enable_o(wb_enable),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_data)
    );

    // Retirement port mirrors the write-back bus
    assign rf_write_enable_o = wb_enable;
    assign rf_write_addr_o   = wb_addr;
    assign rf_write_data_o   = wb_data;

endmodule

// File: tb_clock_gen.sv
// Free-running clock and a power-on reset held high for a fixed number of rising edges
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // Reset drops shortly after the last reset edge, like any other input
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #2;
        reset_o = 1'b0;
    end

endmodule

// File: tb_rv_core.sv
// Core registers are never reset, so every program writes its source registers before use
`timescale 1ns/1ns

module tb_rv_core;
    import rv_isa_pkg::*;

    localparam logic [31:0] reset_address = 32'h0000_1000;
    localparam int          imem_aw       = 6;
    localparam int          retire_limit  = 200;
    localparam int          drain_cycles  = 8;

    logic        clk;
    logic        gen_reset;
    logic        restart;
    logic        reset;
    logic        stall;
    logic        stall_mode;
    logic [31:0] instruction;
    logic [31:0] instr_addr;
    logic [31:0] word_offset;
    logic        wb_enable;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic [31:0] rand_word;
    integer      seed = 32'hb1a2a8bb;

    logic [31:0] imem [0:(1 << imem_aw) - 1];
    logic [31:0] ref_regs [0:31];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] saved_addr [$];
    logic [31:0] saved_data [$];
    int          prog_len;
    int          checks;
    int          errors;
    int          test_errors;

    tb_clock_gen #(.period_ns(40), .reset_cycles(4)) clock0 (
        .clk_o  (clk),
        .reset_o(gen_reset)
    );

    assign reset = gen_reset | restart;

    rv_core_top #(.reset_address(reset_address)) dut0 (
        .clk                  (clk),
        .reset                (reset),
        .stall_i              (stall),
        .instruction_i        (instruction),
        .instruction_address_o(instr_addr),
        .rf_write_enable_o    (wb_enable),
        .rf_write_addr_o      (wb_addr),
        .rf_write_data_o      (wb_data)
    );

    // ----------------------------------------
    // Instruction memory and stall source
    // ----------------------------------------
    // ADDI x0, x0, imm with imm folded from every address bit
    function automatic logic [31:0] nop_fill(input logic [31:0] addr);
        logic [11:0] imm;
        imm = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
        return {imm, 5'd0, F3_ADD_SUB, 5'd0, OPCODE_OP_IMM};
    endfunction

    always_comb begin
        word_offset = (instr_addr - reset_address) >> 2;
        if (word_offset < (1 << imem_aw)) begin
            instruction = imem[word_offset[imem_aw-1:0]];
        end else begin
            instruction = nop_fill(instr_addr);
        end
    end

    initial begin
        stall = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            rand_word = $random(seed);
            stall = stall_mode && rand_word[0];
        end
    end

    // ----------------------------------------
    // Reference model and program building
    // ----------------------------------------
    task automatic model_step(input logic [31:0] word);
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        opcode = word[6:0];
        funct3 = word[14:12];
        rd     = word[11:7];
        a      = ref_regs[word[19:15]];
        b      = (opcode == OPCODE_OP) ? ref_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        case (funct3)
            F3_ADD_SUB: res = (word[30] && opcode == OPCODE_OP) ? a - b : a + b;
            F3_SLL:     res = a << b[4:0];
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_SRL_SRA: begin
                res = a >> b[4:0];
                // Arithmetic form refills the vacated top bits with the sign
                if (word[30] && a[31]) begin
                    res = res | ~(32'hffff_ffff >> b[4:0]);
                end
            end
            F3_OR:      res = a | b;
            default:    res = a & b;
        endcase
        if ((opcode == OPCODE_OP || opcode == OPCODE_OP_IMM) && rd != 5'd0) begin
            ref_regs[rd] = res;
            exp_addr.push_back({27'd0, rd});
            exp_data.push_back(res);
        end
    endtask

    task automatic place_word(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
        model_step(word);
    endtask

    task automatic reg_op(input logic alt, input logic [2:0] funct3,
                          input logic [4:0] rd, rs1, rs2);
        place_word({1'b0, alt, 5'd0, rs2, rs1, funct3, rd, OPCODE_OP});
    endtask

    task automatic imm_op(input logic [11:0] imm, input logic [2:0] funct3,
                          input logic [4:0] rd, rs1);
        place_word({imm, rs1, funct3, rd, OPCODE_OP_IMM});
    endtask

    // ----------------------------------------
    // Checking and collection
    // ----------------------------------------
    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic sample_writeback();
        if (stall) begin
            check_equal("rf_write_enable_o", 32'd0, {31'd0, wb_enable});
        end
        if (wb_enable) begin
            got_addr.push_back({27'd0, wb_addr});
            got_data.push_back(wb_data);
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < (1 << imem_aw); i++) begin
            imem[i] = nop_fill(reset_address + 32'(i) * 32'd4);
        end
    endtask

    // Core is held in reset while the memory is rewritten
    task automatic start_program();
        stall_mode = 1'b0;
        @(posedge clk);
        #2;
        restart = 1'b1;
        fill_memory();
        exp_addr.delete();
        exp_data.delete();
        prog_len    = 0;
        test_errors = 0;
    endtask

    task automatic release_reset();
        repeat (4) @(posedge clk);
        #2;
        restart = 1'b0;
    endtask

    task automatic collect_retirements(input string name);
        int cycles;
        int expected_n;
        int i;
        expected_n = exp_addr.size();
        got_addr.delete();
        got_data.delete();
        cycles = 0;
        while (got_addr.size() < expected_n && cycles < retire_limit) begin
            @(negedge clk);
            cycles++;
            sample_writeback();
        end
        if (got_addr.size() < expected_n) begin
            $display("%s: retirements stopped after %0d cycles, %0d of %0d seen",
                     name, cycles, got_addr.size(), expected_n);
            errors++;
            test_errors++;
        end
        // Anything retiring after the program is an extra write
        repeat (drain_cycles) begin
            @(negedge clk);
            sample_writeback();
        end
        check_equal("rf_write_enable_o count", expected_n, got_addr.size());
        for (i = 0; i < expected_n && i < got_addr.size(); i++) begin
            check_equal("rf_write_addr_o", exp_addr[i], got_addr[i]);
            check_equal("rf_write_data_o", exp_data[i], got_data[i]);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, test_errors);
    endtask

    task automatic run_program(input string name);
        release_reset();
        collect_retirements(name);
        finish_test(name);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_behaviour();
        start_program();
        imm_op(12'd5, F3_ADD_SUB, 5'd1, 5'd0);
        @(posedge clk);
        @(negedge clk);
        check_equal("instruction_address_o", reset_address, instr_addr);
        check_equal("rf_write_enable_o", 32'd0, {31'd0, wb_enable});
        release_reset();
        @(negedge clk);
        check_equal("instruction_address_o", reset_address, instr_addr);
        check_equal("rf_write_enable_o", 32'd0, {31'd0, wb_enable});
        @(negedge clk);
        check_equal("rf_write_enable_o", 32'd0, {31'd0, wb_enable});
        // First retirement slot for the word at the reset address
        @(negedge clk);
        check_equal("rf_write_enable_o", 32'd1, {31'd0, wb_enable});
        check_equal("rf_write_addr_o", exp_addr[0], {27'd0, wb_addr});
        check_equal("rf_write_data_o", exp_data[0], wb_data);
        finish_test("reset");
    endtask

    task automatic load_alu_program();
        imm_op(-12'd1, F3_ADD_SUB, 5'd4, 5'd0);
        imm_op(12'd3, F3_ADD_SUB, 5'd3, 5'd0);
        imm_op(12'd100, F3_ADD_SUB, 5'd2, 5'd0);
        imm_op(-12'd7, F3_ADD_SUB, 5'd1, 5'd0);
        reg_op(1'b0, F3_ADD_SUB, 5'd10, 5'd1, 5'd2);
        reg_op(1'b1, F3_ADD_SUB, 5'd11, 5'd1, 5'd2);
        reg_op(1'b0, F3_SLL, 5'd12, 5'd2, 5'd3);
        reg_op(1'b0, F3_SLT, 5'd13, 5'd1, 5'd2);
        reg_op(1'b0, F3_SLTU, 5'd14, 5'd1, 5'd2);
        reg_op(1'b0, F3_SLT, 5'd15, 5'd2, 5'd1);
        reg_op(1'b0, F3_SLTU, 5'd16, 5'd2, 5'd1);
        reg_op(1'b0, F3_XOR, 5'd17, 5'd1, 5'd4);
        reg_op(1'b0, F3_SRL_SRA, 5'd18, 5'd1, 5'd3);
        reg_op(1'b1, F3_SRL_SRA, 5'd19, 5'd1, 5'd3);
        reg_op(1'b0, F3_OR, 5'd20, 5'd2, 5'd3);
        reg_op(1'b0, F3_AND, 5'd21, 5'd1, 5'd2);
    endtask

    task automatic reg_reg_ops();
        start_program();
        load_alu_program();
        saved_addr = exp_addr;
        saved_data = exp_data;
        run_program("register-register");
    endtask

    task automatic imm_ops();
        start_program();
        imm_op(-12'd7, F3_ADD_SUB, 5'd1, 5'd0);
        imm_op(-12'd100, F3_ADD_SUB, 5'd5, 5'd1);
        imm_op(-12'd1, F3_SLT, 5'd6, 5'd1);
        imm_op(-12'd1, F3_SLTU, 5'd7, 5'd1);
        imm_op(12'd5, F3_SLTU, 5'd8, 5'd1);
        imm_op(-12'd1, F3_XOR, 5'd9, 5'd1);
        imm_op(12'h0f0, F3_OR, 5'd10, 5'd1);
        imm_op(12'h7f0, F3_AND, 5'd11, 5'd1);
        imm_op(12'd4, F3_SLL, 5'd12, 5'd1);
        imm_op(12'd4, F3_SRL_SRA, 5'd13, 5'd1);
        imm_op(12'h404, F3_SRL_SRA, 5'd14, 5'd1);
        imm_op(12'h41f, F3_SRL_SRA, 5'd15, 5'd1);
        run_program("immediate");
    endtask

    // Adjacent pairs hit the bubble, one-apart pairs hit the bypass
    task automatic dependency_chain();
        start_program();
        imm_op(12'd3, F3_ADD_SUB, 5'd1, 5'd0);
        imm_op(12'd4, F3_ADD_SUB, 5'd1, 5'd1);
        reg_op(1'b0, F3_ADD_SUB, 5'd2, 5'd1, 5'd1);
        imm_op(12'd1, F3_ADD_SUB, 5'd3, 5'd0);
        reg_op(1'b1, F3_ADD_SUB, 5'd4, 5'd2, 5'd3);
        reg_op(1'b0, F3_SLL, 5'd5, 5'd4, 5'd3);
        imm_op(12'd2, F3_ADD_SUB, 5'd6, 5'd0);
        reg_op(1'b0, F3_XOR, 5'd7, 5'd5, 5'd6);
        reg_op(1'b0, F3_AND, 5'd8, 5'd7, 5'd7);
        reg_op(1'b0, F3_OR, 5'd9, 5'd8, 5'd5);
        run_program("dependency");
    endtask

    task automatic random_stall();
        int i;
        start_program();
        load_alu_program();
        @(negedge clk);
        stall_mode = 1'b1;
        release_reset();
        collect_retirements("stall");
        stall_mode = 1'b0;
        check_equal("rf_write_enable_o count", saved_addr.size(), got_addr.size());
        for (i = 0; i < saved_addr.size() && i < got_addr.size(); i++) begin
            check_equal("rf_write_addr_o", saved_addr[i], got_addr[i]);
            check_equal("rf_write_data_o", saved_data[i], got_data[i]);
        end
        finish_test("stall");
    endtask

    task automatic x0_and_unsupported();
        start_program();
        imm_op(12'd21, F3_ADD_SUB, 5'd1, 5'd0);
        imm_op(12'd9, F3_ADD_SUB, 5'd5, 5'd0);
        reg_op(1'b0, F3_ADD_SUB, 5'd0, 5'd1, 5'd5);
        imm_op(12'd5, F3_ADD_SUB, 5'd0, 5'd1);
        // LUI, load, store and branch words all retire as nothing
        place_word({20'h12345, 5'd5, 7'b0110111});
        place_word({12'd0, 5'd1, 3'b010, 5'd5, 7'b0000011});
        place_word({7'd0, 5'd5, 5'd1, 3'b010, 5'd4, 7'b0100011});
        place_word({7'd0, 5'd1, 5'd1, 3'b000, 5'd8, 7'b1100011});
        reg_op(1'b0, F3_ADD_SUB, 5'd6, 5'd0, 5'd1);
        imm_op(12'd0, F3_ADD_SUB, 5'd7, 5'd5);
        reg_op(1'b1, F3_ADD_SUB, 5'd8, 5'd1, 5'd0);
        reg_op(1'b0, F3_OR, 5'd9, 5'd0, 5'd0);
        run_program("x0 and unsupported");
    endtask

    task automatic wait_power_on_reset();
        int cycles;
        cycles = 0;
        while (gen_reset && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (gen_reset) begin
            $display("Power-on reset was never released");
            errors++;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        restart     = 1'b0;
        stall_mode  = 1'b0;
        prog_len    = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = 32'd0;
        end
        fill_memory();
        wait_power_on_reset();
        reset_behaviour();
        reg_reg_ops();
        imm_ops();
        dependency_chain();
        random_stall();
        x0_and_unsupported();
        $display("All tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
rv_isa_pkg.sv
core_pkg.sv
pipeline_if.sv
fetch_decode.sv
register_bank.sv
execute_unit.sv
rv_core_top.sv
tb_clock_gen.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and scan the log for the failure message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: simulation reported failures"
    exit 1
fi
exit 0
